/* build.f */
+incdir+.
rp_pkg.sv
hk_cfg_if.sv
adc_capture.sv
dac_mixer.sv
dac_output.sv
hk_axil_regs.sv
rp_analog_top.sv
tb_clk_gen.sv
tb_rp_analog.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the analog data path testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f build.f --top-module tb_rp_analog -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
  echo "testbench reported failure, see $LOG"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
  echo "no pass line in $LOG"
  exit 1
fi
exit 0

/* tb_rp_analog.sv */
/*
 * testbench for the analog data path
 * AXI4-Lite register access, reference model of the ADC code, mixer
 * saturation and DAC offset binary, immediate assertions on the pins
 */
`timescale 1ns/100ps
`default_nettype none

`include "rp_defines.svh"

module tb_rp_analog import rp_pkg::*; ();

  typedef logic [`RP_SMP_W-1:0] raw_t;

  localparam int TMO  = 100;                       // handshake wait limit
  localparam int LOW  = `RP_SMP_W - `RP_ADC_KEEP;  // dropped ADC bits
  localparam int HALF = 1 << (`RP_SMP_W-1);        // half scale

  logic adc_clk;
  logic rst_n;
  raw_t adc_dat_a, adc_dat_b;
  raw_t dac_dat_a, dac_dat_b;
  logic dac_reset;
  logic [7:0] led;
  logic [`HK_ADDR_W-1:0] awaddr, araddr;
  logic [`HK_DATA_W-1:0] wdata, rdata;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [1:0] bresp, rresp;

  tb_clk_gen i_clk (.adc_clk(adc_clk), .rst_n_o(rst_n));

  rp_analog_top UUT (
    .adc_clk (adc_clk), .rst_n_i (rst_n),
    .adc_dat_a_i (adc_dat_a), .adc_dat_b_i (adc_dat_b),
    .dac_dat_a_o (dac_dat_a), .dac_dat_b_o (dac_dat_b),
    .dac_reset_o (dac_reset), .led_o (led),
    .s_axil_awaddr_i (awaddr), .s_axil_awvalid_i (awvalid), .s_axil_awready_o (awready),
    .s_axil_wdata_i (wdata), .s_axil_wvalid_i (wvalid), .s_axil_wready_o (wready),
    .s_axil_bresp_o (bresp), .s_axil_bvalid_o (bvalid), .s_axil_bready_i (bready),
    .s_axil_araddr_i (araddr), .s_axil_arvalid_i (arvalid), .s_axil_arready_o (arready),
    .s_axil_rdata_o (rdata), .s_axil_rresp_o (rresp), .s_axil_rvalid_o (rvalid),
    .s_axil_rready_i (rready)
  );

  //////////////////////////////
  // reference model
  //////////////////////////////

  // negative slope offset binary to signed, low bits copy the lowest kept bit
  function automatic int conv_adc(input raw_t raw);
    smp_t v;
    v = smp_t'(raw ^ raw_t'(HALF - 1));
    for (int i = 0; i < LOW; i++)
      v[i] = v[LOW];
    return int'(v);
  endfunction

  function automatic int sat_sum(input int s);
    if (s > HALF - 1)
      return HALF - 1;
    if (s < -HALF)
      return -HALF;
    return s;
  endfunction

  function automatic raw_t to_offset(input int v);
    int u;
    u = v + HALF; // zero lands at mid scale
    return u[`RP_SMP_W-1:0];
  endfunction

  function automatic int rand_smp();
    smp_t v;
    v = smp_t'($urandom);
    return int'(v);
  endfunction

  function automatic logic [31:0] ctrl_word(input logic loop, input logic fa,
                                            input logic fb, input logic [7:0] led_v);
    hk_ctrl_t c;
    c              = '0;
    c.digital_loop = loop;
    c.feed_a       = fa;
    c.feed_b       = fb;
    c.led          = led_v;
    return 32'(c);
  endfunction

  //////////////////////////////
  // checks and bus tasks
  //////////////////////////////

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("ERR t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout at %0t, %s never happened", $time, what);
    $display("Simulation FAILED");
    $fatal(1, "wait timed out");
  endtask

  // hold keeps BREADY low for that many extra cycles
  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                           input int hold, output logic [1:0] resp);
    int n;
    @(posedge adc_clk);
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    n = 0;
    do
    begin
      @(negedge adc_clk);
      n++;
      if (n > TMO)
        timeout_fail("write address and data accept");
    end
    while (!(awready && wready));
    @(posedge adc_clk);
    awvalid <= 1'b0; // handshake taken on this edge
    wvalid  <= 1'b0;
    n = 0;
    do
    begin
      @(negedge adc_clk);
      n++;
      if (n > TMO)
        timeout_fail("write response valid");
    end
    while (!bvalid);
    resp = bresp;
    repeat (hold)
    begin
      @(negedge adc_clk);
      expect_eq("s_axil_bvalid_o", 32'(1'b1), 32'(bvalid)); // stalled response
    end
    @(posedge adc_clk);
    bready <= 1'b1;
    @(posedge adc_clk);
    bready <= 1'b0;
    n = 0;
    do
    begin
      @(negedge adc_clk);
      n++;
      if (n > TMO)
        timeout_fail("write response release");
    end
    while (bvalid);
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    @(posedge adc_clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    n = 0;
    do
    begin
      @(negedge adc_clk);
      n++;
      if (n > TMO)
        timeout_fail("read address accept");
    end
    while (!arready);
    @(posedge adc_clk);
    arvalid <= 1'b0;
    n = 0;
    do
    begin
      @(negedge adc_clk);
      n++;
      if (n > TMO)
        timeout_fail("read data valid");
    end
    while (!rvalid);
    data = rdata;
    resp = rresp;
    @(posedge adc_clk);
    rready <= 1'b1;
    @(posedge adc_clk);
    rready <= 1'b0;
  endtask

  task automatic set_levels(input int la, input int lb);
    logic [1:0] r;
    write_reg(`HK_OFS_LEVEL_A, {$urandom} & 32'hFFFF_C000 | 32'(raw_t'(la)), 0, r);
    expect_eq("s_axil_bresp_o", 32'(`HK_RESP_OKAY), 32'(r));
    write_reg(`HK_OFS_LEVEL_B, 32'(raw_t'(lb)), 0, r);
    expect_eq("s_axil_bresp_o", 32'(`HK_RESP_OKAY), 32'(r));
  endtask

  // 6 edges cover the 4 cycle path and any pending write
  task automatic settle();
    repeat (6) @(posedge adc_clk);
    @(negedge adc_clk);
  endtask

  // mixer ch A drives DAC B, ch B drives DAC A
  task automatic check_dac(input int ch_a, input int ch_b);
    expect_eq("dac_dat_b_o", 32'(to_offset(ch_a)), 32'(dac_dat_b));
    expect_eq("dac_dat_a_o", 32'(to_offset(ch_b)), 32'(dac_dat_a));
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial
  begin
    logic [31:0] rd, ctrl_w, lvl_w;
    logic [1:0]  rsp;
    hk_word_u    wu;
    raw_t        ra, rb;
    int          la, lb, n;
    void'($urandom(86));
    adc_dat_a = '0;
    adc_dat_b = '0;
    awaddr = '0;
    araddr = '0;
    wdata = '0;
    awvalid = 1'b0;
    wvalid = 1'b0;
    bready = 1'b0;
    arvalid = 1'b0;
    rready = 1'b0;

    // reset state
    @(negedge adc_clk);
    expect_eq("dac_reset_o", 32'(1'b1), 32'(dac_reset));
    check_dac(0, 0);
    expect_eq("led_o", 32'h0, 32'(led));
    expect_eq("s_axil_bvalid_o", 32'h0, 32'(bvalid));
    expect_eq("s_axil_rvalid_o", 32'h0, 32'(rvalid));
    n = 0;
    while (!rst_n)
    begin
      @(negedge adc_clk);
      n++;
      if (n > TMO)
        timeout_fail("reset release");
    end
    expect_eq("dac_reset_o", 32'(1'b1), 32'(dac_reset)); // no edge yet since release
    @(posedge adc_clk);
    @(negedge adc_clk);
    expect_eq("dac_reset_o", 32'h0, 32'(dac_reset));
    read_reg(`HK_OFS_ID, rd, rsp);
    expect_eq("s_axil_rdata_o", `HK_ID_VALUE, rd);
    expect_eq("s_axil_rresp_o", 32'(`HK_RESP_OKAY), 32'(rsp));

    // registers, reserved bits read zero
    ctrl_w = $urandom;
    wu     = ctrl_w;
    write_reg(`HK_OFS_CTRL, ctrl_w, 0, rsp);
    expect_eq("s_axil_bresp_o", 32'(`HK_RESP_OKAY), 32'(rsp));
    read_reg(`HK_OFS_CTRL, rd, rsp);
    expect_eq("s_axil_rdata_o", ctrl_w & 32'h0000_FF07, rd);
    expect_eq("led_o", 32'(8'({wu.ctrl.led, wu.ctrl.led} >> 4)), 32'(led)); // nibbles swapped
    lvl_w = $urandom;
    write_reg(`HK_OFS_LEVEL_A, lvl_w, 0, rsp);
    read_reg(`HK_OFS_LEVEL_A, rd, rsp);
    expect_eq("s_axil_rdata_o", lvl_w & 32'h3FFF, rd);
    lvl_w = $urandom;
    write_reg(`HK_OFS_LEVEL_B, lvl_w, 0, rsp);
    read_reg(`HK_OFS_LEVEL_B, rd, rsp);
    expect_eq("s_axil_rdata_o", lvl_w & 32'h3FFF, rd);
    write_reg(4'h6, 32'hFFFF_FFFF, 0, rsp); // hole in the map
    expect_eq("s_axil_bresp_o", 32'(`HK_RESP_SLVERR), 32'(rsp));
    read_reg(4'h6, rd, rsp);
    expect_eq("s_axil_rresp_o", 32'(`HK_RESP_SLVERR), 32'(rsp));
    expect_eq("s_axil_rdata_o", 32'h0, rd);
    write_reg(`HK_OFS_ID, 32'h0, 0, rsp);
    expect_eq("s_axil_bresp_o", 32'(`HK_RESP_SLVERR), 32'(rsp));
    read_reg(`HK_OFS_CTRL, rd, rsp);
    expect_eq("s_axil_rdata_o", ctrl_w & 32'h0000_FF07, rd); // untouched by bad writes
    write_reg(`HK_OFS_CTRL, ctrl_word(1'b0, 1'b0, 1'b0, 8'h5A), 5, rsp); // BREADY held off
    expect_eq("led_o", 32'hA5, 32'(led));

    // levels only
    for (int i = 0; i < 8; i++)
    begin
      la = rand_smp();
      lb = rand_smp();
      set_levels(la, lb);
      settle();
      check_dac(la, lb);
    end

    // feed-through of crossed ADC pins
    write_reg(`HK_OFS_CTRL, ctrl_word(1'b0, 1'b1, 1'b1, 8'h00), 0, rsp);
    for (int i = 0; i < 16; i++)
    begin
      la = rand_smp();
      lb = rand_smp();
      ra = raw_t'($urandom);
      rb = raw_t'($urandom);
      set_levels(la, lb);
      @(posedge adc_clk);
      adc_dat_a <= ra;
      adc_dat_b <= rb;
      settle();
      check_dac(sat_sum(la + conv_adc(rb)), sat_sum(lb + conv_adc(ra)));
    end
    set_levels(HALF - 1, HALF - 1); // both channels past the top
    @(posedge adc_clk);
    adc_dat_a <= '0;
    adc_dat_b <= '0;
    settle();
    expect_eq("dac_dat_a_o", 32'h3FFF, 32'(dac_dat_a));
    expect_eq("dac_dat_b_o", 32'h3FFF, 32'(dac_dat_b));
    set_levels(-HALF, -HALF); // and past the bottom
    @(posedge adc_clk);
    adc_dat_a <= '1;
    adc_dat_b <= '1;
    settle();
    expect_eq("dac_dat_a_o", 32'h0, 32'(dac_dat_a));
    expect_eq("dac_dat_b_o", 32'h0, 32'(dac_dat_b));

    // digital loopback, ch A integrates its level
    la = 64 + $urandom_range(0, 500);
    lb = rand_smp();
    set_levels(la, lb);
    write_reg(`HK_OFS_CTRL, ctrl_word(1'b1, 1'b1, 1'b0, 8'h00), 0, rsp);
    n = 0;
    do
    begin
      @(posedge adc_clk);
      adc_dat_a <= raw_t'($urandom); // pins must not matter
      adc_dat_b <= raw_t'($urandom);
      @(negedge adc_clk);
      n++;
      if (n > 40 * TMO)
        timeout_fail("loopback reaching full scale");
    end
    while (dac_dat_b != 14'h3FFF);
    for (int i = 0; i < 20; i++)
    begin
      @(posedge adc_clk);
      adc_dat_a <= raw_t'($urandom);
      adc_dat_b <= raw_t'($urandom);
      @(negedge adc_clk);
      expect_eq("dac_dat_b_o", 32'h3FFF, 32'(dac_dat_b));
      expect_eq("dac_dat_a_o", 32'(to_offset(lb)), 32'(dac_dat_a));
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
/*
 * testbench clock and reset
 * 100 ns adc_clk, reset held low for the first two cycles
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic adc_clk,
  output logic rst_n_o
);

  localparam int HALF_NS = 50; // half of the 100 ns period

  initial
  begin
    adc_clk = 1'b0;
    forever #(HALF_NS) adc_clk = ~adc_clk;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge adc_clk);
    rst_n_o <= 1'b1; // released on the second rising edge
  end

endmodule

`default_nettype wire

/* rp_analog_top.sv */
/*
 * analog data path top
 * ADC capture -> level mixer -> DAC output, with digital loopback
 * and the AXI4-Lite housekeeping registers
 */
`timescale 1ns/100ps
`default_nettype none

`include "rp_defines.svh"

module rp_analog_top import rp_pkg::*; (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  // converters
  input  logic [`RP_SMP_W-1:0]  adc_dat_a_i,
  input  logic [`RP_SMP_W-1:0]  adc_dat_b_i,
  output logic [`RP_SMP_W-1:0]  dac_dat_a_o,
  output logic [`RP_SMP_W-1:0]  dac_dat_b_o,
  output logic                  dac_reset_o,
  output logic [7:0]            led_o,
  // housekeeping bus
  input  logic [`HK_ADDR_W-1:0] s_axil_awaddr_i,
  input  logic                  s_axil_awvalid_i,
  output logic                  s_axil_awready_o,
  input  logic [`HK_DATA_W-1:0] s_axil_wdata_i,
  input  logic                  s_axil_wvalid_i,
  output logic                  s_axil_wready_o,
  output logic [1:0]            s_axil_bresp_o,
  output logic                  s_axil_bvalid_o,
  input  logic                  s_axil_bready_i,
  input  logic [`HK_ADDR_W-1:0] s_axil_araddr_i,
  input  logic                  s_axil_arvalid_i,
  output logic                  s_axil_arready_o,
  output logic [`HK_DATA_W-1:0] s_axil_rdata_o,
  output logic [1:0]            s_axil_rresp_o,
  output logic                  s_axil_rvalid_o,
  input  logic                  s_axil_rready_i
);

  smp_t adc_a; // captured, crossed
  smp_t adc_b;
  smp_t mix_a; // saturated, also loopback source
  smp_t mix_b;

  hk_cfg_if cfg ();

  adc_capture i_adc (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_raw_a_i (adc_dat_a_i),
    .adc_raw_b_i (adc_dat_b_i),
    .loop_a_i    (mix_a),
    .loop_b_i    (mix_b),
    .cfg         (cfg.capture),
    .smp_a_o     (adc_a),
    .smp_b_o     (adc_b)
  );

  dac_mixer i_mix (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .smp_a_i (adc_a),
    .smp_b_i (adc_b),
    .cfg     (cfg.mixer),
    .mix_a_o (mix_a),
    .mix_b_o (mix_b)
  );

  dac_output i_dac (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .mix_a_i     (mix_a),
    .mix_b_i     (mix_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .dac_reset_o (dac_reset_o)
  );

  hk_axil_regs i_hk (
    .adc_clk          (adc_clk),
    .rst_n_i          (rst_n_i),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .cfg              (cfg.regs),
    .led_o            (led_o)
  );

endmodule

`default_nettype wire

/* hk_axil_regs.sv */
/*
 * housekeeping register block
 * AXI4-Lite slave with CTRL, LEVEL_A, LEVEL_B and a read only ID,
 * SLVERR on unmapped offsets, LED nibbles swapped at the output
 */
`timescale 1ns/100ps
`default_nettype none

`include "rp_defines.svh"

module hk_axil_regs import rp_pkg::*; (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  // write address / data / response
  input  logic [`HK_ADDR_W-1:0] s_axil_awaddr_i,
  input  logic                  s_axil_awvalid_i,
  output logic                  s_axil_awready_o,
  input  logic [`HK_DATA_W-1:0] s_axil_wdata_i,
  input  logic                  s_axil_wvalid_i,
  output logic                  s_axil_wready_o,
  output logic [1:0]            s_axil_bresp_o,
  output logic                  s_axil_bvalid_o,
  input  logic                  s_axil_bready_i,
  // read address / data
  input  logic [`HK_ADDR_W-1:0] s_axil_araddr_i,
  input  logic                  s_axil_arvalid_i,
  output logic                  s_axil_arready_o,
  output logic [`HK_DATA_W-1:0] s_axil_rdata_o,
  output logic [1:0]            s_axil_rresp_o,
  output logic                  s_axil_rvalid_o,
  input  logic                  s_axil_rready_i,
  hk_cfg_if.regs                cfg,
  output logic [7:0]            led_o
);

  hk_ctrl_t ctrl_q;    // CTRL, reserved bits kept zero
  smp_t     level_a_q;
  smp_t     level_b_q;

  hk_word_u wr_word;   // write data, either view
  hk_ctrl_t wr_ctrl;   // control view, reserved cleared
  hk_word_u rd_mux;    // read data before register
  logic     wr_go;     // start of write accept pulse
  logic     wr_en;     // write handshake this cycle
  logic     wr_map;    // writable offset
  logic     rd_go;
  logic     rd_en;
  logic     rd_map;    // readable offset

  ////////////////////////////////
  // write channel
  ////////////////////////////////

  assign wr_go = s_axil_awvalid_i & s_axil_wvalid_i & ~s_axil_awready_o & ~s_axil_bvalid_o;
  assign wr_en = s_axil_awready_o & s_axil_awvalid_i & s_axil_wvalid_i;
  assign wr_word = s_axil_wdata_i; // strobes ignored, full word

  always_comb
  begin
    wr_ctrl              = '0;
    wr_ctrl.digital_loop = wr_word.ctrl.digital_loop;
    wr_ctrl.feed_a       = wr_word.ctrl.feed_a;
    wr_ctrl.feed_b       = wr_word.ctrl.feed_b;
    wr_ctrl.led          = wr_word.ctrl.led;
    case (s_axil_awaddr_i)
      `HK_OFS_CTRL, `HK_OFS_LEVEL_A, `HK_OFS_LEVEL_B: wr_map = 1'b1;
      default:                                        wr_map = 1'b0; // ID too
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      s_axil_awready_o <= 1'b0;
      s_axil_wready_o  <= 1'b0;
      s_axil_bvalid_o  <= 1'b0;
      s_axil_bresp_o   <= `HK_RESP_OKAY;
    end
    else
    begin
      s_axil_awready_o <= wr_go; // one cycle pulse, both together
      s_axil_wready_o  <= wr_go;
      if (wr_en)
      begin
        s_axil_bvalid_o <= 1'b1;
        s_axil_bresp_o  <= wr_map ? `HK_RESP_OKAY : `HK_RESP_SLVERR;
      end
      else if (s_axil_bready_i)
        s_axil_bvalid_o <= 1'b0;
    end
  end

  // register file
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ctrl_q    <= `HK_CTRL_RST;
      level_a_q <= `HK_LEVEL_RST;
      level_b_q <= `HK_LEVEL_RST;
    end
    else if (wr_en)
    begin
      case (s_axil_awaddr_i)
        `HK_OFS_CTRL:    ctrl_q    <= wr_ctrl;
        `HK_OFS_LEVEL_A: level_a_q <= wr_word.level.level;
        `HK_OFS_LEVEL_B: level_b_q <= wr_word.level.level;
        default:         ;         // ID and holes change nothing
      endcase
    end
  end

  ////////////////////////////////
  // read channel
  ////////////////////////////////

  assign rd_go = s_axil_arvalid_i & ~s_axil_arready_o & ~s_axil_rvalid_o;
  assign rd_en = s_axil_arready_o & s_axil_arvalid_i;

  always_comb
  begin
    rd_mux = '0;
    rd_map = 1'b1;
    case (s_axil_araddr_i)
      `HK_OFS_CTRL:    rd_mux.ctrl        = ctrl_q;
      `HK_OFS_LEVEL_A: rd_mux.level.level = level_a_q;
      `HK_OFS_LEVEL_B: rd_mux.level.level = level_b_q;
      `HK_OFS_ID:      rd_mux             = `HK_ID_VALUE;
      default:         rd_map             = 1'b0; // zero data
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      s_axil_arready_o <= 1'b0;
      s_axil_rvalid_o  <= 1'b0;
      s_axil_rresp_o   <= `HK_RESP_OKAY;
    end
    else
    begin
      s_axil_arready_o <= rd_go;
      if (rd_en)
      begin
        s_axil_rvalid_o <= 1'b1;
        s_axil_rresp_o  <= rd_map ? `HK_RESP_OKAY : `HK_RESP_SLVERR;
      end
      else if (s_axil_rready_i)
        s_axil_rvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (rd_en)
      s_axil_rdata_o <= rd_mux; // held until RREADY
  end

  // configuration out
  assign cfg.digital_loop = ctrl_q.digital_loop;
  assign cfg.feed_a       = ctrl_q.feed_a;
  assign cfg.feed_b       = ctrl_q.feed_b;
  assign cfg.level_a      = level_a_q;
  assign cfg.level_b      = level_b_q;

  assign led_o = {ctrl_q.led[3:0], ctrl_q.led[7:4]}; // nibble swap at the pins

endmodule

`default_nettype wire

/* dac_output.sv */
/*
 * DAC output side
 * two's complement to offset binary, channel swap at the pins,
 * and the DAC reset held until the first edge after release
 */
`timescale 1ns/100ps
`default_nettype none

`include "rp_defines.svh"

module dac_output import rp_pkg::*; (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  smp_t                 mix_a_i,
  input  smp_t                 mix_b_i,
  output logic [`RP_SMP_W-1:0] dac_dat_a_o,
  output logic [`RP_SMP_W-1:0] dac_dat_b_o,
  output logic                 dac_reset_o
);

  localparam logic [`RP_SMP_W-1:0] DAC_MID = 1'b1 << (`RP_SMP_W-1); // offset zero

  // msb flip gives offset binary
  function automatic logic [`RP_SMP_W-1:0] to_ofs(smp_t s);
    return {~s[`RP_SMP_W-1], s[`RP_SMP_W-2:0]};
  endfunction

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_dat_a_o <= DAC_MID; // pins idle at mid scale
      dac_dat_b_o <= DAC_MID;
    end
    else
    begin
      dac_dat_a_o <= to_ofs(mix_b_i); // ch B -> DAC A
      dac_dat_b_o <= to_ofs(mix_a_i); // ch A -> DAC B
    end
  end

  // DAC reset, active high
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      dac_reset_o <= 1'b1;
    else
      dac_reset_o <= 1'b0; // released one edge after rst_n_i
  end

endmodule

`default_nettype wire

/* dac_mixer.sv */
/*
 * DAC processing stage
 * per channel DC level plus optional ADC feed-through,
 * saturated to 14 bits and registered, also feeds the loopback
 */
`timescale 1ns/100ps
`default_nettype none

`include "rp_defines.svh"

module dac_mixer import rp_pkg::*; (
  input  logic     adc_clk,
  input  logic     rst_n_i,
  input  smp_t     smp_a_i,
  input  smp_t     smp_b_i,
  hk_cfg_if.mixer  cfg,
  output smp_t     mix_a_o,
  output smp_t     mix_b_o
);

  sum_t sum_a; // unsaturated, one guard bit
  sum_t sum_b;

  // two top bits differ -> overflow, clamp to +8191 / -8192
  function automatic smp_t sat(sum_t s);
    if (s[`RP_SUM_W-1] ^ s[`RP_SUM_W-2])
      return smp_t'({s[`RP_SUM_W-1], {(`RP_SMP_W-1){~s[`RP_SUM_W-1]}}});
    return s[`RP_SMP_W-1:0];
  endfunction

  always_comb
  begin
    sum_a = sum_t'(cfg.level_a) + (cfg.feed_a ? sum_t'(smp_a_i) : sum_t'(0));
    sum_b = sum_t'(cfg.level_b) + (cfg.feed_b ? sum_t'(smp_b_i) : sum_t'(0));
  end

  ////////////////////////////////
  // output register
  ////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mix_a_o <= '0;
      mix_b_o <= '0;
    end
    else
    begin
      mix_a_o <= sat(sum_a);
      mix_b_o <= sat(sum_b);
    end
  end

endmodule

`default_nettype wire

/* adc_capture.sv */
/*
 * ADC input side
 * registers the parallel ADC words, converts negative slope offset
 * binary to two's complement at 12 bit significance, swaps the
 * channels and selects digital loopback in a second register stage
 */
`timescale 1ns/100ps
`default_nettype none

`include "rp_defines.svh"

module adc_capture import rp_pkg::*; (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  logic [`RP_SMP_W-1:0] adc_raw_a_i, // pin A
  input  logic [`RP_SMP_W-1:0] adc_raw_b_i, // pin B
  input  smp_t                 loop_a_i,    // mixer A for loopback
  input  smp_t                 loop_b_i,    // mixer B for loopback
  hk_cfg_if.capture            cfg,
  output smp_t                 smp_a_o,
  output smp_t                 smp_b_o
);

  localparam int LSB_W = `RP_SMP_W - `RP_ADC_KEEP; // dropped low bits

  logic [`RP_SMP_W-1:0] raw_a_q; // pin registers
  logic [`RP_SMP_W-1:0] raw_b_q;

  // neg slope offset binary -> two's complement, low bits follow bit 2
  function automatic smp_t adc_conv(logic [`RP_SMP_W-1:0] raw);
    logic [`RP_SMP_W-1:0] tc;
    tc = {raw[`RP_SMP_W-1], ~raw[`RP_SMP_W-2:0]};
    return smp_t'({tc[`RP_SMP_W-1:LSB_W], {LSB_W{tc[LSB_W]}}});
  endfunction

  ////////////////////////////////
  // stage 1, pins
  ////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end
    else
    begin
      raw_a_q <= adc_raw_a_i;
      raw_b_q <= adc_raw_b_i;
    end
  end

  ////////////////////////////////
  // stage 2, cross and loopback
  ////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      smp_a_o <= '0;
      smp_b_o <= '0;
    end
    else if (cfg.digital_loop)
    begin
      smp_a_o <= loop_a_i; // channels stay straight in loop
      smp_b_o <= loop_b_i;
    end
    else
    begin
      smp_a_o <= adc_conv(raw_b_q); // pin B -> ch A
      smp_b_o <= adc_conv(raw_a_q); // pin A -> ch B
    end
  end

endmodule

`default_nettype wire

/* hk_cfg_if.sv */
/*
 * housekeeping configuration
 * static register outputs from the register block to the
 * capture and mixer stages, no handshake
 */
`timescale 1ns/100ps
`default_nettype none

interface hk_cfg_if import rp_pkg::*; ();

  logic digital_loop; // DAC channels back into ADC path
  logic feed_a;       // ADC A into mixer A
  logic feed_b;       // ADC B into mixer B
  smp_t level_a;      // DC level, channel A
  smp_t level_b;      // DC level, channel B

  modport regs (
    output digital_loop, feed_a, feed_b, level_a, level_b
  );

  modport capture (
    input digital_loop
  );

  modport mixer (
    input feed_a, feed_b, level_a, level_b
  );

endinterface

`default_nettype wire

/* rp_pkg.sv */
/*
 * analog data path types
 * signed sample and sum words, housekeeping register views
 */
`default_nettype none

`include "rp_defines.svh"

package rp_pkg;

  typedef logic signed [`RP_SMP_W-1:0] smp_t; // two's complement sample
  typedef logic signed [`RP_SUM_W-1:0] sum_t; // one guard bit for the sum

  // control word at CTRL
  typedef struct packed {
    logic [15:0] rsvd_hi;      // 31:16, read as zero
    logic [7:0]  led;          // 15:8
    logic [4:0]  rsvd_lo;      // 7:3, read as zero
    logic        feed_b;       // bit 2
    logic        feed_a;       // bit 1
    logic        digital_loop; // bit 0
  } hk_ctrl_t;

  // level word at LEVEL_A / LEVEL_B
  typedef struct packed {
    logic [17:0] rsvd;         // 31:14, read as zero
    smp_t        level;        // 13:0 signed DC level
  } hk_level_t;

  // one bus word, two decodings picked by address
  typedef union packed {
    hk_ctrl_t  ctrl;
    hk_level_t level;
  } hk_word_u;

endpackage

`default_nettype wire

/* rp_defines.svh */
/*
 * analog data path constants
 * sample widths, housekeeping bus geometry, register map,
 * identification word and register reset values
 */
`ifndef RP_DEFINES_SVH
`define RP_DEFINES_SVH

// sample path widths
`define RP_SMP_W       14            // ADC/DAC word
`define RP_SUM_W       15            // level + sample, before saturation
`define RP_ADC_KEEP    12            // significant ADC bits

// housekeeping AXI4-Lite geometry
`define HK_ADDR_W      4
`define HK_DATA_W      32

// register byte offsets
`define HK_OFS_CTRL    4'h0
`define HK_OFS_LEVEL_A 4'h4
`define HK_OFS_LEVEL_B 4'h8
`define HK_OFS_ID      4'hC

`define HK_ID_VALUE    32'h5250_0A01 // read only identification
`define HK_CTRL_RST    32'h0000_0000 // loop, feeds and leds off
`define HK_LEVEL_RST   14'h0000      // zero DC level

// AXI response codes
`define HK_RESP_OKAY   2'b00
`define HK_RESP_SLVERR 2'b10

`endif
